// ==== hdl/wr_dma_pkg.sv ====
package wr_dma_pkg;

  ////////////////////////////////////////
  // Widths

  // Memory data bus and byte lanes
  localparam int data_w    = 64;
  localparam int strb_w    = data_w / 8;
  // Low address bits that pick a byte inside one word
  localparam int mask_bits = $clog2(strb_w);

  // Address, length and stream sideband widths
  localparam int addr_w = 16;
  localparam int len_w  = 16;
  localparam int dest_w = 8;
  localparam int user_w = 2;

  ////////////////////////////////////////
  // Packed types

  // One beat of the incoming stream, 73 bits
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] keep;
    logic              last;
  } beat_t;

  // Metadata latched on the first beat of a packet, 26 bits
  typedef struct packed {
    logic [addr_w-1:0] start_addr;
    logic [dest_w-1:0] dest;
    logic [user_w-1:0] user;
  } pkt_meta_t;

  // One aligned memory write request, 90 bits
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } mem_wr_t;

  // Receive descriptor handed to the consumer, 42 bits
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [len_w-1:0]  len;
    logic [dest_w-1:0] dest;
    logic [user_w-1:0] user;
  } recv_desc_t;

endpackage

// ==== hdl/wr_frame_ctrl.sv ====
`timescale 1ns/1ps

module wr_frame_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              beat_acc,
  input  logic                              word_acc,
  input  logic                              pkt_end,
  input  logic [wr_dma_pkg::addr_w-1:0]     wr_base_addr,
  input  logic [wr_dma_pkg::dest_w-1:0]     s_dest,
  input  logic [wr_dma_pkg::user_w-1:0]     s_user,
  output logic                              first_beat,
  output logic [wr_dma_pkg::mask_bits:0]    offset,
  output logic [wr_dma_pkg::addr_w-1:0]     wr_addr,
  output wr_dma_pkg::pkt_meta_t             meta
);

  ////////////////////////////////////////
  // Packet state

  typedef enum logic {
    st_idle,
    st_proc
  } state_t;

  state_t state;

  // Start of a new packet
  // Either nothing is in flight, or the previous packet's last word leaves on
  // the same edge that the new first beat is taken
  logic latch_info;

  // Address of the word after the one currently offered to memory
  logic [wr_dma_pkg::addr_w-1:0] next_addr;

  // Word aligned version of the captured base address
  logic [wr_dma_pkg::addr_w-1:0] aligned_addr;

  assign latch_info = ((state == st_idle) || pkt_end) && beat_acc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (beat_acc)
            state <= st_proc;
        end
        st_proc: begin
          // A beat taken with the last word is already the next packet
          if (pkt_end && !beat_acc)
            state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Metadata capture

  // Base address, dest, user and byte shift are taken from the first beat
  // The shift is a full word minus the base's low bits, so an aligned base
  // gives a shift of strb_w and the second stage drops out completely
  always_ff @(posedge clk) begin
    if (latch_info) begin
      meta.start_addr <= wr_base_addr;
      meta.dest       <= s_dest;
      meta.user       <= s_user;
      offset          <= {1'b1, {wr_dma_pkg::mask_bits{1'b0}}} -
                         {1'b0, wr_base_addr[wr_dma_pkg::mask_bits-1:0]};
    end
  end

  // First word flag lines up with the first memory word, one cycle after the
  // first beat is latched, and stays up until memory takes that word
  always_ff @(posedge clk) begin
    if (rst)
      first_beat <= 1'b0;
    else
      first_beat <= latch_info || (first_beat && !word_acc);
  end

  ////////////////////////////////////////
  // Write address

  assign aligned_addr = {meta.start_addr[wr_dma_pkg::addr_w-1:wr_dma_pkg::mask_bits],
                         {wr_dma_pkg::mask_bits{1'b0}}};

  // Every accepted word moves the address on by one word
  always_ff @(posedge clk) begin
    if (word_acc)
      next_addr <= wr_addr + wr_dma_pkg::addr_w'(wr_dma_pkg::strb_w);
  end

  // The first word of a packet goes to the aligned start, later words follow
  assign wr_addr = first_beat ? aligned_addr : next_addr;

endmodule

// ==== hdl/wr_realign.sv ====
`timescale 1ns/1ps

module wr_realign (
  input  logic                              clk,
  input  logic                              rst,
  input  wr_dma_pkg::beat_t                 s_beat,
  input  logic                              s_valid,
  output logic                              s_ready,
  input  logic                              first_beat,
  input  logic [wr_dma_pkg::mask_bits:0]    offset,
  input  logic                              desc_block,
  input  logic                              mem_wr_ready,
  output logic                              beat_acc,
  output logic                              word_acc,
  output logic                              pkt_end,
  output logic                              wr_en,
  output logic [wr_dma_pkg::data_w-1:0]     wr_data,
  output logic [wr_dma_pkg::strb_w-1:0]     wr_strb,
  output logic                              wr_last
);

  // Stage 1 holds the newest beat, stage 2 the beat before it
  logic [wr_dma_pkg::data_w-1:0] data_1;
  logic [wr_dma_pkg::data_w-1:0] data_2;
  logic [wr_dma_pkg::strb_w-1:0] strb_1;
  logic [wr_dma_pkg::strb_w-1:0] strb_2;
  logic                          last_1;

  // Set while the extra trailing word of a packet is on the output
  logic extra_r;

  // Last beat still has bytes that do not fit in the current output word
  logic strb_left;
  logic extra_cycle;

  // Stage 2 strobes as seen by the shifter
  logic [wr_dma_pkg::strb_w-1:0] strb_2_eff;

  // Double width words before the shift
  logic [2*wr_dma_pkg::data_w-1:0] data_cat;
  logic [2*wr_dma_pkg::strb_w-1:0] strb_cat;

  ////////////////////////////////////////
  // Handshakes

  // Bytes of stage 1 above the shift spill into one more word
  // After the extra word is taken stage 1 strobes are zero, so this drops
  assign strb_left   = |(strb_1 >> offset);
  assign extra_cycle = last_1 && strb_left;

  // Input waits for memory, for the extra word, and for a free descriptor
  // slot when the beat would close the packet
  assign s_ready  = mem_wr_ready && !extra_cycle && !(s_beat.last && desc_block);
  assign beat_acc = s_valid && s_ready;
  assign word_acc = wr_en && mem_wr_ready;

  // Last word is the last beat itself, or the extra word that follows it
  assign wr_last = wr_en && ((last_1 && !extra_cycle) || extra_r);
  assign pkt_end = wr_last && mem_wr_ready;

  ////////////////////////////////////////
  // Pipeline stages

  always_ff @(posedge clk) begin
    if (rst) begin
      strb_1 <= '0;
      last_1 <= 1'b0;
    end else if (word_acc && extra_cycle) begin
      // Stage 1 has been shifted into stage 2, only the spill is left
      strb_1 <= '0;
      last_1 <= 1'b0;
    end else if (beat_acc) begin
      strb_1 <= s_beat.keep;
      last_1 <= s_beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_acc)
      data_1 <= s_beat.data;
  end

  // Stage 2 only moves when memory takes a word
  always_ff @(posedge clk) begin
    if (word_acc)
      data_2 <= data_1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      strb_2  <= '0;
      extra_r <= 1'b0;
    end else if (word_acc) begin
      strb_2  <= strb_1;
      extra_r <= extra_cycle;
    end
  end

  // Word valid state
  // A new beat gives a word next cycle, an extra word keeps the output up,
  // and a refused word holds until memory takes it
  always_ff @(posedge clk) begin
    if (rst)
      wr_en <= 1'b0;
    else
      wr_en <= beat_acc || (word_acc && extra_cycle) || (wr_en && !mem_wr_ready);
  end

  ////////////////////////////////////////
  // Byte shift

  // On the first word stage 2 still holds the previous packet, so its lanes
  // must not be written
  assign strb_2_eff = first_beat ? '0 : strb_2;

  assign data_cat = {data_1, data_2} >> {offset, 3'b000};
  assign strb_cat = {strb_1, strb_2_eff} >> offset;

  assign wr_data = data_cat[wr_dma_pkg::data_w-1:0];
  assign wr_strb = strb_cat[wr_dma_pkg::strb_w-1:0];

endmodule

// ==== hdl/recv_desc_builder.sv ====
`timescale 1ns/1ps

module recv_desc_builder (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              word_acc,
  input  logic                              pkt_end,
  input  logic                              first_beat,
  input  logic [wr_dma_pkg::strb_w-1:0]     wr_strb,
  input  wr_dma_pkg::pkt_meta_t             meta,
  output logic                              desc_block,
  output wr_dma_pkg::recv_desc_t            recv_desc,
  output logic                              recv_desc_valid,
  input  logic                              recv_desc_ready
);

  localparam int cnt_w = wr_dma_pkg::mask_bits + 1;

  // Bytes in the word currently offered to memory
  logic [cnt_w-1:0] one_count;

  // Running length and the length including the current word
  logic [wr_dma_pkg::len_w-1:0] pkt_len;
  logic [wr_dma_pkg::len_w-1:0] next_len;

  // Descriptor for the packet whose last word is on the output
  wr_dma_pkg::recv_desc_t fresh_desc;

  // Finished descriptor waiting for the held one to be taken
  wr_dma_pkg::recv_desc_t pend_desc;
  logic                   late_write;

  // Descriptor register loads
  logic load_now;
  logic load_late;

  ////////////////////////////////////////
  // Length

  // Strobes can have holes, so every lane is counted
  always_comb begin
    one_count = '0;
    for (int i = 0; i < wr_dma_pkg::strb_w; i++)
      one_count = one_count + cnt_w'(wr_strb[i]);
  end

  // The first word of a packet restarts the count
  assign next_len = first_beat ? wr_dma_pkg::len_w'(one_count) :
                                 pkt_len + wr_dma_pkg::len_w'(one_count);

  always_ff @(posedge clk) begin
    if (rst)
      pkt_len <= '0;
    else if (word_acc)
      pkt_len <= next_len;
  end

  ////////////////////////////////////////
  // Descriptor

  always_comb begin
    fresh_desc.addr = meta.start_addr;
    fresh_desc.len  = next_len;
    fresh_desc.dest = meta.dest;
    fresh_desc.user = meta.user;
  end

  // The held descriptor blocks the slot until the consumer takes it
  assign desc_block = recv_desc_valid && !recv_desc_ready;

  assign load_now  = pkt_end && !desc_block;
  assign load_late = late_write && recv_desc_ready;

  // A packet that ends while the slot is blocked is parked here
  // The next packet may already be under way, so its fields are saved now
  always_ff @(posedge clk) begin
    if (pkt_end && desc_block)
      pend_desc <= fresh_desc;
  end

  always_ff @(posedge clk) begin
    if (rst)
      late_write <= 1'b0;
    else if (pkt_end && desc_block)
      late_write <= 1'b1;
    else if (recv_desc_ready)
      late_write <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (load_now)
      recv_desc <= fresh_desc;
    else if (load_late)
      recv_desc <= pend_desc;
  end

  // Valid stays up when a new descriptor replaces the one just taken
  always_ff @(posedge clk) begin
    if (rst)
      recv_desc_valid <= 1'b0;
    else if (load_now || load_late)
      recv_desc_valid <= 1'b1;
    else if (recv_desc_ready)
      recv_desc_valid <= 1'b0;
  end

endmodule

// ==== hdl/axis_wr_dma.sv ====
`timescale 1ns/1ps

module axis_wr_dma (
  input  logic                              clk,
  input  logic                              rst,

  // Incoming stream
  input  wr_dma_pkg::beat_t                 s_beat,
  input  logic                              s_valid,
  output logic                              s_ready,
  input  logic [wr_dma_pkg::dest_w-1:0]     s_dest,
  input  logic [wr_dma_pkg::user_w-1:0]     s_user,

  // Byte address of the packet, sampled with its first beat
  input  logic [wr_dma_pkg::addr_w-1:0]     wr_base_addr,

  // Memory write port
  output wr_dma_pkg::mem_wr_t               mem_wr,
  input  logic                              mem_wr_ready,

  // Receive descriptor
  output wr_dma_pkg::recv_desc_t            recv_desc,
  output logic                              recv_desc_valid,
  input  logic                              recv_desc_ready
);

  ////////////////////////////////////////
  // Internal wiring

  // Transfer events from the realigner
  logic beat_acc;
  logic word_acc;
  logic pkt_end;

  // Packet framing
  logic                              first_beat;
  logic [wr_dma_pkg::mask_bits:0]    offset;
  logic [wr_dma_pkg::addr_w-1:0]     wr_addr;
  wr_dma_pkg::pkt_meta_t             meta;
  logic                              desc_block;

  // Realigned write word
  logic                              wr_en;
  logic [wr_dma_pkg::data_w-1:0]     wr_data;
  logic [wr_dma_pkg::strb_w-1:0]     wr_strb;
  logic                              wr_last;

  wr_frame_ctrl frame_ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .beat_acc     (beat_acc),
    .word_acc     (word_acc),
    .pkt_end      (pkt_end),
    .wr_base_addr (wr_base_addr),
    .s_dest       (s_dest),
    .s_user       (s_user),
    .first_beat   (first_beat),
    .offset       (offset),
    .wr_addr      (wr_addr),
    .meta         (meta)
  );

  wr_realign realign_i (
    .clk          (clk),
    .rst          (rst),
    .s_beat       (s_beat),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .first_beat   (first_beat),
    .offset       (offset),
    .desc_block   (desc_block),
    .mem_wr_ready (mem_wr_ready),
    .beat_acc     (beat_acc),
    .word_acc     (word_acc),
    .pkt_end      (pkt_end),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .wr_strb      (wr_strb),
    .wr_last      (wr_last)
  );

  recv_desc_builder desc_builder_i (
    .clk             (clk),
    .rst             (rst),
    .word_acc        (word_acc),
    .pkt_end         (pkt_end),
    .first_beat      (first_beat),
    .wr_strb         (wr_strb),
    .meta            (meta),
    .desc_block      (desc_block),
    .recv_desc       (recv_desc),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready)
  );

  // Address comes from framing, everything else from the realigner
  assign mem_wr = '{en: wr_en, addr: wr_addr, data: wr_data, strb: wr_strb, last: wr_last};

endmodule

// ==== bench/axis_wr_dma_properties.sv ====
`timescale 1ns/1ps

module axis_wr_dma_properties (
  input logic                   clk,
  input logic                   rst,
  input wr_dma_pkg::mem_wr_t    mem_wr,
  input logic                   mem_wr_ready,
  input wr_dma_pkg::recv_desc_t recv_desc,
  input logic                   recv_desc_valid,
  input logic                   recv_desc_ready
);

  // A refused memory word keeps its address, data, strobes and last flag
  mem_hold: assert property (@(posedge clk) disable iff (rst)
    mem_wr.en && !mem_wr_ready |=> mem_wr.en && $stable(mem_wr))
    else $error("memory write request changed while stalled");

  // A descriptor that is not taken stays valid and unchanged
  desc_hold: assert property (@(posedge clk) disable iff (rst)
    recv_desc_valid && !recv_desc_ready |=> recv_desc_valid && $stable(recv_desc))
    else $error("receive descriptor changed before it was taken");

  // Nothing is offered on either output port right after reset
  reset_quiet: assert property (@(posedge clk)
    rst |=> !mem_wr.en && !recv_desc_valid)
    else $error("write enable or descriptor valid high after reset");

endmodule

bind axis_wr_dma axis_wr_dma_properties props_i (
  .clk             (clk),
  .rst             (rst),
  .mem_wr          (mem_wr),
  .mem_wr_ready    (mem_wr_ready),
  .recv_desc       (recv_desc),
  .recv_desc_valid (recv_desc_valid),
  .recv_desc_ready (recv_desc_ready)
);

// ==== bench/axis_wr_dma_tb.sv ====
`timescale 1ns/1ps

module axis_wr_dma_tb;

  // One packet of the table, with the ready stall modes used while it is sent
  typedef struct packed {
    logic [wr_dma_pkg::addr_w-1:0] base;
    logic [wr_dma_pkg::len_w-1:0]  len;
    logic [wr_dma_pkg::dest_w-1:0] dest;
    logic [wr_dma_pkg::user_w-1:0] user;
    logic                          mem_stall;
    logic                          desc_stall;
  } row_t;

  localparam int n_rows     = 16;
  localparam int beat_limit = 2000;
  localparam int desc_limit = 5000;

  logic                          clk = 1'b0;
  logic                          rst;
  wr_dma_pkg::beat_t             s_beat;
  logic                          s_valid;
  logic                          s_ready;
  logic [wr_dma_pkg::dest_w-1:0] s_dest;
  logic [wr_dma_pkg::user_w-1:0] s_user;
  logic [wr_dma_pkg::addr_w-1:0] wr_base_addr;
  wr_dma_pkg::mem_wr_t           mem_wr;
  logic                          mem_wr_ready;
  wr_dma_pkg::recv_desc_t        recv_desc;
  logic                          recv_desc_valid;
  logic                          recv_desc_ready;

  row_t        rows [n_rows];
  logic [7:0]  mem [0:65535];
  logic        mem_stall_on;
  logic        desc_stall_on;
  int          desc_count = 0;
  int          wr_pkt = 0;
  logic [15:0] end_word;
  integer      seed = 32'hb9f;
  logic [31:0] rnd_mem;
  logic [31:0] rnd_desc;
  int          cycles;

  always #4 clk = ~clk;

  // All port names match the testbench signals
  axis_wr_dma axis_wr_dma_i (.*);

  ////////////////////////////////////////
  // Helpers

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Byte k of packet r, an incrementing count that differs per packet
  function automatic logic [7:0] pkt_byte(input int r, input int k);
    return 8'(r * 16 + k + 1);
  endfunction

  // Background memory contents, folded from all sixteen address bits
  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'hc3;
  endfunction

  function automatic row_t make_row(input logic [15:0] base, input logic [15:0] len,
                                    input logic [7:0] dest, input logic [1:0] user,
                                    input logic mem_stall, input logic desc_stall);
    return '{base: base, len: len, dest: dest, user: user,
             mem_stall: mem_stall, desc_stall: desc_stall};
  endfunction

  // Columns are base, length, dest, user, memory stall, descriptor stall
  // Packets sit 0x100 apart so each one has untouched bytes around it
  task automatic load_table();
    rows[0]  = make_row(16'h0100, 16'd1,  8'h11, 2'd0, 1'b0, 1'b0);
    rows[1]  = make_row(16'h0203, 16'd1,  8'h22, 2'd1, 1'b0, 1'b0);
    rows[2]  = make_row(16'h0307, 16'd1,  8'h33, 2'd2, 1'b0, 1'b0);
    rows[3]  = make_row(16'h0400, 16'd8,  8'h44, 2'd3, 1'b0, 1'b0);
    rows[4]  = make_row(16'h0500, 16'd32, 8'h55, 2'd0, 1'b0, 1'b0);
    rows[5]  = make_row(16'h0605, 16'd3,  8'h66, 2'd1, 1'b0, 1'b0);
    rows[6]  = make_row(16'h0705, 16'd4,  8'h77, 2'd2, 1'b0, 1'b0);
    rows[7]  = make_row(16'h0802, 16'd16, 8'h88, 2'd3, 1'b0, 1'b0);
    rows[8]  = make_row(16'h0906, 16'd13, 8'h99, 2'd0, 1'b0, 1'b0);
    rows[9]  = make_row(16'h0a01, 16'd15, 8'haa, 2'd1, 1'b0, 1'b0);
    rows[10] = make_row(16'h0b03, 16'd45, 8'hbb, 2'd2, 1'b1, 1'b0);
    rows[11] = make_row(16'h0c07, 16'd29, 8'hcc, 2'd3, 1'b1, 1'b1);
    rows[12] = make_row(16'h0d00, 16'd1,  8'hdd, 2'd0, 1'b0, 1'b1);
    rows[13] = make_row(16'h0e04, 16'd2,  8'hee, 2'd1, 1'b1, 1'b1);
    rows[14] = make_row(16'h0f06, 16'd50, 8'hf0, 2'd2, 1'b1, 1'b1);
    rows[15] = make_row(16'h1002, 16'd7,  8'h0f, 2'd3, 1'b0, 1'b1);
  endtask

  // Sends one packet beat by beat, keep is partial only on the last beat
  task automatic send_packet(input int r);
    int          len;
    int          beats;
    int          waited;
    logic [63:0] word;
    len   = int'(rows[r].len);
    beats = (len + 7) / 8;
    for (int b = 0; b < beats; b++) begin
      for (int i = 0; i < 8; i++)
        word[8*i +: 8] = pkt_byte(r, 8*b + i);
      @(negedge clk);
      s_valid      = 1'b1;
      s_beat.data  = word;
      s_beat.last  = (b == beats - 1);
      s_beat.keep  = s_beat.last ? 8'hff >> (8*beats - len) : 8'hff;
      s_dest       = rows[r].dest;
      s_user       = rows[r].user;
      wr_base_addr = rows[r].base;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > beat_limit)
          stop_on_error($sformatf("Timed out waiting for s_ready in packet %0d", r));
      end while (!s_ready);
    end
  endtask

  // Packet bytes must be in place and the word neighbourhood left alone
  task automatic check_region(input int r);
    int          base;
    int          len;
    int          lo;
    int          hi;
    logic [15:0] a;
    base = int'(rows[r].base);
    len  = int'(rows[r].len);
    lo   = (base / 8) * 8 - 8;
    hi   = ((base + len + 7) / 8) * 8 + 8;
    for (int x = lo; x < hi; x++) begin
      a = 16'(x);
      if (x >= base && x < base + len)
        check_value($sformatf("mem[0x%0h]", a), 64'(mem[a]), 64'(pkt_byte(r, x - base)));
      else
        check_value($sformatf("mem[0x%0h]", a), 64'(mem[a]), 64'(fill_byte(a)));
    end
  endtask

  ////////////////////////////////////////
  // Memory, ready and descriptor models

  // Writes land under strobe on the edge where the word is accepted
  // Words of a packet come in order and the one holding its final byte
  // must be the only one marked last
  always @(posedge clk) begin
    if (!rst && mem_wr.en && mem_wr_ready) begin
      check_value("mem_wr.addr low bits",
                  64'(mem_wr.addr[wr_dma_pkg::mask_bits-1:0]), 64'd0);
      if (wr_pkt >= n_rows)
        stop_on_error("A memory write arrived with no packet left to match it");
      else begin
        end_word = 16'(((int'(rows[wr_pkt].base) + int'(rows[wr_pkt].len) - 1) / 8) * 8);
        check_value("mem_wr.last", 64'(mem_wr.last), 64'(mem_wr.addr == end_word));
        if (mem_wr.last)
          wr_pkt = wr_pkt + 1;
      end
      for (int i = 0; i < 8; i++)
        if (mem_wr.strb[i])
          mem[mem_wr.addr + 16'(i)] = mem_wr.data[8*i +: 8];
    end
  end

  // Stalled rows see random ready, the descriptor side is mostly held low
  always @(negedge clk) begin
    rnd_mem         = $random(seed);
    rnd_desc        = $random(seed);
    mem_wr_ready    = mem_stall_on ? (rnd_mem[2:0] > 3'd2) : 1'b1;
    recv_desc_ready = desc_stall_on ? (rnd_desc[1:0] == 2'd0) : 1'b1;
  end

  // Descriptors must follow the table order with base, length, dest and user
  always @(posedge clk) begin
    if (!rst && recv_desc_valid && recv_desc_ready) begin
      if (desc_count >= n_rows)
        stop_on_error("A descriptor arrived with no packet left to match it");
      else begin
        check_value("recv_desc.addr", 64'(recv_desc.addr), 64'(rows[desc_count].base));
        check_value("recv_desc.len", 64'(recv_desc.len), 64'(rows[desc_count].len));
        check_value("recv_desc.dest", 64'(recv_desc.dest), 64'(rows[desc_count].dest));
        check_value("recv_desc.user", 64'(recv_desc.user), 64'(rows[desc_count].user));
        desc_count = desc_count + 1;
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence

  initial begin
    rst             = 1'b1;
    s_valid         = 1'b0;
    s_beat          = '0;
    s_dest          = '0;
    s_user          = '0;
    wr_base_addr    = '0;
    mem_wr_ready    = 1'b0;
    recv_desc_ready = 1'b0;
    mem_stall_on    = 1'b0;
    desc_stall_on   = 1'b0;
    load_table();
    for (int a = 0; a < 65536; a++)
      mem[16'(a)] = fill_byte(16'(a));
    repeat (10) @(negedge clk);
    rst = 1'b0;
    check_value("mem_wr.en", 64'(mem_wr.en), 64'd0);
    check_value("recv_desc_valid", 64'(recv_desc_valid), 64'd0);
    @(posedge clk);
    // Packets go back to back, stall modes switch with each row
    for (int r = 0; r < n_rows; r++) begin
      mem_stall_on  = rows[r].mem_stall;
      desc_stall_on = rows[r].desc_stall;
      send_packet(r);
    end
    mem_stall_on  = 1'b0;
    desc_stall_on = 1'b0;
    @(negedge clk);
    s_valid = 1'b0;
    cycles = 0;
    while (desc_count < n_rows) begin
      @(negedge clk);
      cycles++;
      if (cycles > desc_limit)
        stop_on_error("Timed out waiting for the remaining receive descriptors");
    end
    for (int r = 0; r < n_rows; r++)
      check_region(r);
    // A late duplicate would still reach the descriptor model within a few cycles
    repeat (20) @(negedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== build.f ====
hdl/wr_dma_pkg.sv
hdl/wr_frame_ctrl.sv
hdl/wr_realign.sv
hdl/recv_desc_builder.sv
hdl/axis_wr_dma.sv
bench/axis_wr_dma_properties.sv
bench/axis_wr_dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the write DMA testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module axis_wr_dma_tb \
  -f build.f \
  -o axis_wr_dma_sim

./obj_dir/axis_wr_dma_sim
